// ==== Bender.yml ====
package:
  name: ghash

sources:
  - ghash_pkg.sv
  - ghash_prod_if.sv
  - ghash_key_sched.sv
  - ghash_pair_mult.sv
  - ghash_accum.sv
  - ghash_core.sv
  - target: test
    files:
      - ghash_tb.sv

// ==== ghash_accum.sv ====
`default_nettype none

module ghash_accum (
    input  logic                  clk,
    input  logic                  arst_n,
    input  ghash_pkg::ghash_blk_t h1,
    input  ghash_pkg::ghash_blk_t h2,
    ghash_prod_if.consumer        prod,
    output logic                  tag_valid,
    output ghash_pkg::ghash_blk_t tag
);
    import ghash_pkg::*;

    // Running GHASH value
    ghash_blk_t acc_q;

    // Feedback path
    ghash_blk_t acc_base;
    ghash_blk_t h_fb;
    ghash_blk_t acc_next;

    // Set between a first and its last strobe
    logic       open_q;

    //////////////////////////////////////////////////
    // Feedback fold
    //////////////////////////////////////////////////

    // acc*H^n ^ prod with n the block count
    always_comb
    begin
        // New message starts from zero
        acc_base = prod.first ? '0 : acc_q;
        h_fb     = (prod.count == 2'd2) ? h2 : h1;
        acc_next = gf128_mult(acc_base, h_fb) ^ prod.prod;
    end

    always_ff @(posedge clk)
    begin
        if (prod.valid)
        begin
            acc_q <= acc_next;
        end
        // Tag holds the final fold
        if (prod.valid && prod.last)
        begin
            tag <= acc_next;
        end
    end

    //////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            tag_valid <= 1'b0;
            open_q    <= 1'b0;
        end
        else
        begin
            tag_valid <= prod.valid && prod.last;
            if (prod.valid)
            begin
                // Last closes, first alone opens
                open_q <= !prod.last;
            end
        end
    end

    // Messages never overlap
    a_first_after_last: assert property (
        @(posedge clk) disable iff (!arst_n)
        (prod.valid && prod.first) |-> !open_q
    );

endmodule

`default_nettype wire

// ==== ghash_core.sv ====
`default_nettype none

module ghash_core (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  h_load,
    input  ghash_pkg::ghash_blk_t h_key,
    input  logic                  blk_valid,
    input  ghash_pkg::ghash_blk_t blk_x1,
    input  ghash_pkg::ghash_blk_t blk_x2,
    input  ghash_pkg::ghash_cnt_t blk_count,
    input  logic                  blk_first,
    input  logic                  blk_last,
    output logic                  h_ready,
    output logic                  tag_valid,
    output ghash_pkg::ghash_blk_t tag
);
    import ghash_pkg::*;

    // H and H^2 shared by both datapath stages
    ghash_blk_t h1;
    ghash_blk_t h2;

    // Multiply to accumulate
    ghash_prod_if prod_if ();

    //////////////////////////////////////////////////
    // Stages
    //////////////////////////////////////////////////

    ghash_key_sched u_key_sched (
        .clk     (clk),
        .arst_n  (arst_n),
        .h_load  (h_load),
        .h_key   (h_key),
        .h1      (h1),
        .h2      (h2),
        .h_ready (h_ready)
    );

    // Edge 0 registers the strobe
    ghash_pair_mult u_pair_mult (
        .clk       (clk),
        .arst_n    (arst_n),
        .blk_valid (blk_valid),
        .blk_x1    (blk_x1),
        .blk_x2    (blk_x2),
        .blk_count (blk_count),
        .blk_first (blk_first),
        .blk_last  (blk_last),
        .h1        (h1),
        .h2        (h2),
        .h_ready   (h_ready),
        .prod      (prod_if.producer)
    );

    // Edge 1 folds and emits the tag
    ghash_accum u_accum (
        .clk       (clk),
        .arst_n    (arst_n),
        .h1        (h1),
        .h2        (h2),
        .prod      (prod_if.consumer),
        .tag_valid (tag_valid),
        .tag       (tag)
    );

endmodule

`default_nettype wire

// ==== ghash_key_sched.sv ====
`default_nettype none

module ghash_key_sched (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  h_load,
    input  ghash_pkg::ghash_blk_t h_key,
    output ghash_pkg::ghash_blk_t h1,
    output ghash_pkg::ghash_blk_t h2,
    output logic                  h_ready
);
    import ghash_pkg::*;

    key_state_t state_q;

    //////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////

    // Load from empty or ready, square takes one cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state_q <= KEY_EMPTY;
        end
        else
        begin
            case (state_q)
                KEY_EMPTY, KEY_READY:
                begin
                    if (h_load)
                    begin
                        state_q <= KEY_SQUARE;
                    end
                end
                KEY_SQUARE:
                begin
                    state_q <= KEY_READY;
                end
                default:
                begin
                    state_q <= KEY_EMPTY;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Key registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        // Capture H on the load strobe
        if (h_load && state_q != KEY_SQUARE)
        begin
            h1 <= h_key;
        end
        // H^2 from the stored H
        if (state_q == KEY_SQUARE)
        begin
            h2 <= gf128_mult(h1, h1);
        end
    end

    // Ready once H^2 is written
    assign h_ready = (state_q == KEY_READY);

    // No reload while the square is in progress
    a_no_load_in_square: assert property (
        @(posedge clk) disable iff (!arst_n)
        state_q == KEY_SQUARE |-> !h_load
    );

endmodule

`default_nettype wire

// ==== ghash_pair_mult.sv ====
`default_nettype none

module ghash_pair_mult (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  blk_valid,
    input  ghash_pkg::ghash_blk_t blk_x1,
    input  ghash_pkg::ghash_blk_t blk_x2,
    input  ghash_pkg::ghash_cnt_t blk_count,
    input  logic                  blk_first,
    input  logic                  blk_last,
    input  ghash_pkg::ghash_blk_t h1,
    input  ghash_pkg::ghash_blk_t h2,
    input  logic                  h_ready,
    ghash_prod_if.producer        prod
);
    import ghash_pkg::*;

    // Registered strobe
    logic       valid_q;
    logic       first_q;
    logic       last_q;
    ghash_cnt_t count_q;
    ghash_blk_t x1_q;
    ghash_blk_t x2_q;

    // Multiplier operands and results
    logic       pair;
    ghash_blk_t h_x1;
    ghash_blk_t prod_x1;
    ghash_blk_t prod_x2;

    //////////////////////////////////////////////////
    // Input registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= blk_valid;
        end
    end

    // Payload and framing held with the strobe
    always_ff @(posedge clk)
    begin
        if (blk_valid)
        begin
            first_q <= blk_first;
            last_q  <= blk_last;
            count_q <= blk_count;
            x1_q    <= blk_x1;
            x2_q    <= blk_x2;
        end
    end

    //////////////////////////////////////////////////
    // Paired multiply
    //////////////////////////////////////////////////

    always_comb
    begin
        pair    = (count_q == 2'd2);
        // x1 sees H^2 when a second block follows it
        h_x1    = pair ? h2 : h1;
        prod_x1 = gf128_mult(x1_q, h_x1);
        prod_x2 = gf128_mult(x2_q, h1);
        prod.valid = valid_q;
        prod.first = first_q;
        prod.last  = last_q;
        prod.count = count_q;
        prod.prod  = pair ? (prod_x1 ^ prod_x2) : prod_x1;
    end

    // Blocks only under a valid key
    a_blk_needs_key: assert property (
        @(posedge clk) disable iff (!arst_n)
        blk_valid |-> h_ready
    );

    a_blk_count_legal: assert property (
        @(posedge clk) disable iff (!arst_n)
        blk_valid |-> (blk_count == 2'd1 || blk_count == 2'd2)
    );

endmodule

`default_nettype wire

// ==== ghash_pkg.sv ====
`default_nettype none

package ghash_pkg;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    // One GHASH block in GCM bit order
    // Index 0 holds the x^0 coefficient
    typedef logic [0:127] ghash_blk_t;

    // Blocks carried by one strobe, legal values 1 and 2
    typedef logic [1:0] ghash_cnt_t;

    // Key scheduler states
    typedef enum logic [1:0]
    {
        KEY_EMPTY,
        KEY_SQUARE,
        KEY_READY
    } key_state_t;

    // Reduction term of x^128 + x^7 + x^2 + x + 1 in reflected order
    localparam ghash_blk_t GF128_R = {8'he1, 120'd0};

    //////////////////////////////////////////////////
    // GF(2^128) multiply
    //////////////////////////////////////////////////

    // Shift-and-add product of x and y
    // Bits of x walk from x^0 upward
    function automatic ghash_blk_t gf128_mult(
        input ghash_blk_t x,
        input ghash_blk_t y
    );
        ghash_blk_t z;
        ghash_blk_t v;
        z = '0;
        v = y;
        for (int i = 0; i < 128; i++)
        begin
            // Add current multiple of y
            if (x[i])
            begin
                z = z ^ v;
            end
            // Multiply v by x and reduce on overflow
            if (v[127])
            begin
                v = (v >> 1) ^ GF128_R;
            end
            else
            begin
                v = v >> 1;
            end
        end
        return z;
    endfunction

endpackage

`default_nettype wire

// ==== ghash_prod_if.sv ====
`default_nettype none

interface ghash_prod_if;
    import ghash_pkg::*;

    // Strobe, high for one cycle per accepted input strobe
    logic       valid;

    // Message framing
    logic       first;
    logic       last;

    // Number of blocks folded into prod
    ghash_cnt_t count;

    // Partial product, x1*H or x1*H^2 ^ x2*H
    ghash_blk_t prod;

    // Multiply stage side
    modport producer (
        output valid,
        output first,
        output last,
        output count,
        output prod
    );

    // Accumulate stage side
    modport consumer (
        input valid,
        input first,
        input last,
        input count,
        input prod
    );

endinterface

`default_nettype wire

// ==== ghash_tb.sv ====
`default_nettype none

module ghash_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import ghash_pkg::*;

    logic       clk;
    logic       arst_n;
    logic       h_load;
    ghash_blk_t h_key;
    logic       blk_valid;
    ghash_blk_t blk_x1;
    ghash_blk_t blk_x2;
    ghash_cnt_t blk_count;
    logic       blk_first;
    logic       blk_last;
    logic       h_ready;
    logic       tag_valid;
    ghash_blk_t tag;

    // Free running cycle count, bumped on every rising edge
    int         cyc = 0;
    ghash_blk_t cur_h;
    ghash_blk_t last_tag;

    // Message under construction and the tags still owed by the DUT
    ghash_blk_t msg_q[$];
    ghash_blk_t exp_tags[$];
    int         exp_cyc[$];

    ghash_core u_ghash_core (
        .clk       (clk),
        .arst_n    (arst_n),
        .h_load    (h_load),
        .h_key     (h_key),
        .blk_valid (blk_valid),
        .blk_x1    (blk_x1),
        .blk_x2    (blk_x2),
        .blk_count (blk_count),
        .blk_first (blk_first),
        .blk_last  (blk_last),
        .h_ready   (h_ready),
        .tag_valid (tag_valid),
        .tag       (tag)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Plain polynomial product, then fold the top half down
    function automatic ghash_blk_t ref_mult(input ghash_blk_t a, input ghash_blk_t b);
        logic [254:0] p;
        logic [254:0] bv;
        ghash_blk_t   r;
        p  = '0;
        bv = '0;
        // p[k] and bv[k] hold the x^k coefficient
        for (int j = 0; j < 128; j++)
        begin
            bv[j] = b[j];
        end
        for (int i = 0; i < 128; i++)
        begin
            if (a[i])
            begin
                p = p ^ (bv << i);
            end
        end
        // x^128 = x^7 + x^2 + x + 1, top bits first
        for (int k = 254; k >= 128; k--)
        begin
            if (p[k])
            begin
                p[k]       = 1'b0;
                p[k - 121] = ~p[k - 121];
                p[k - 126] = ~p[k - 126];
                p[k - 127] = ~p[k - 127];
                p[k - 128] = ~p[k - 128];
            end
        end
        for (int i = 0; i < 128; i++)
        begin
            r[i] = p[i];
        end
        return r;
    endfunction

    // One block per multiply over msg_q
    function automatic ghash_blk_t ref_ghash(input ghash_blk_t h);
        ghash_blk_t y;
        y = '0;
        foreach (msg_q[i])
        begin
            y = ref_mult(y ^ msg_q[i], h);
        end
        return y;
    endfunction

    function automatic ghash_blk_t rand_blk();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    //////////////////////////////////////////////////
    // Error reporting
    //////////////////////////////////////////////////

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        $display("** Error: %s = %h, expected %h", name, got, exp);
        stop_run();
    endtask

    task automatic report_text(input string what);
        $display("Error: %s", what);
        stop_run();
    endtask

    // Tag checker, compares in message order and checks the two edge latency
    always @(negedge clk)
    begin
        ghash_blk_t exp_tag;
        int         exp_at;
        if (tag_valid === 1'b1)
        begin
            assert (exp_tags.size() > 0)
            else report_text("tag_valid raised with no message outstanding");
            if (exp_tags.size() > 0)
            begin
                exp_tag = exp_tags.pop_front();
                exp_at  = exp_cyc.pop_front();
                assert (tag === exp_tag) else report_value("tag", tag, exp_tag);
                assert (cyc == exp_at + 2) else report_value("tag latency", cyc - exp_at, 2);
                last_tag = tag;
            end
        end
    end

    //////////////////////////////////////////////////
    // Drivers
    //////////////////////////////////////////////////

    task automatic load_key(input ghash_blk_t k);
        int load_at;
        int n;
        @(posedge clk);
        #1;
        h_load  = 1'b1;
        h_key   = k;
        load_at = cyc;
        // Edge 0 captures the key
        @(posedge clk);
        #1;
        h_load = 1'b0;
        n = 0;
        @(negedge clk);
        while (h_ready !== 1'b1 && n < 10)
        begin
            @(negedge clk);
            n++;
        end
        assert (h_ready === 1'b1) else report_text("timeout waiting for h_ready");
        assert (cyc - load_at == 2) else report_value("h_ready latency", cyc - load_at, 2);
        cur_h = k;
    endtask

    task automatic build_message(input int n, input bit with_len);
        msg_q.delete();
        repeat (n)
        begin
            msg_q.push_back(rand_blk());
        end
        // GCM length block, no AAD
        if (with_len)
        begin
            msg_q.push_back({64'd0, 64'(n * 128)});
        end
    endtask

    // Pairing: 0 singles, 1 greedy pairs, 2 random, 3 pairs with lone last two
    task automatic send_message(input int mode);
        int         i;
        int         rem;
        ghash_cnt_t cnt;
        exp_tags.push_back(ref_ghash(cur_h));
        i = 0;
        while (i < msg_q.size())
        begin
            rem = msg_q.size() - i;
            if (rem == 1 || mode == 0)
                cnt = 2'd1;
            else if (mode == 1)
                cnt = 2'd2;
            else if (mode == 3)
                cnt = (rem >= 3) ? 2'd2 : 2'd1;
            else
                cnt = ($urandom % 2 == 1) ? 2'd2 : 2'd1;
            @(posedge clk);
            #1;
            blk_valid = 1'b1;
            blk_count = cnt;
            blk_x1    = msg_q[i];
            // x2 is junk on a single
            if (cnt == 2'd2)
                blk_x2 = msg_q[i + 1];
            else
                blk_x2 = rand_blk();
            blk_first = (i == 0);
            blk_last  = (i + cnt == msg_q.size());
            if (blk_last)
            begin
                exp_cyc.push_back(cyc);
            end
            i = i + cnt;
        end
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        blk_valid = 1'b0;
        blk_first = 1'b0;
        blk_last  = 1'b0;
    endtask

    task automatic wait_tags();
        int n;
        n = 0;
        while (exp_tags.size() != 0 && n < 50)
        begin
            @(posedge clk);
            n++;
        end
        assert (exp_tags.size() == 0) else report_text("timeout waiting for tag_valid");
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_reset_and_key();
        @(negedge clk);
        assert (h_ready === 1'b0) else report_value("h_ready", h_ready, 0);
        assert (tag_valid === 1'b0) else report_value("tag_valid", tag_valid, 0);
        load_key(rand_blk());
    endtask

    task automatic test_single_blocks();
        // Known H of the all zero AES key
        load_key(128'h66e94bd4ef8a2c3b884cfa59ca342b2e);
        // Ciphertext of the zero block under the zero key
        msg_q.delete();
        msg_q.push_back(128'h0388dace60b6a392f328c2b971b2fe78);
        send_message(0);
        idle();
        wait_tags();
        assert (last_tag === 128'h5e2ec746917062882c85b0685353deb7)
        else report_value("tag", last_tag, 128'h5e2ec746917062882c85b0685353deb7);
        // Same block with its length block as one pair
        msg_q.push_back(128'h00000000000000000000000000000080);
        send_message(1);
        idle();
        wait_tags();
        assert (last_tag === 128'hf38cbb1ad69223dcc3457ae5b6b0f885)
        else report_value("tag", last_tag, 128'hf38cbb1ad69223dcc3457ae5b6b0f885);
        repeat (8)
        begin
            build_message(1, 1'b0);
            send_message(0);
            idle();
            wait_tags();
        end
    endtask

    task automatic test_long_messages();
        build_message(5, 1'b1);
        send_message(3);
        idle();
        wait_tags();
        build_message(6, 1'b1);
        send_message(1);
        idle();
        wait_tags();
        build_message(3, 1'b1);
        send_message(3);
        idle();
        wait_tags();
    endtask

    // No idle between messages, so several are in flight
    task automatic test_back_to_back(input int count);
        repeat (count)
        begin
            build_message(1 + $urandom % 9, $urandom % 2 == 1);
            send_message(2);
        end
        idle();
        wait_tags();
    endtask

    task automatic test_key_reload();
        load_key(rand_blk());
        test_back_to_back(4);
        load_key(rand_blk());
        build_message(4, 1'b1);
        send_message(3);
        idle();
        wait_tags();
    endtask

    initial
    begin
        void'($urandom(32'h6d8b));
        cur_h     = '0;
        last_tag  = '0;
        arst_n    = 1'b0;
        h_load    = 1'b0;
        h_key     = '0;
        blk_valid = 1'b0;
        blk_x1    = '0;
        blk_x2    = '0;
        blk_count = 2'd1;
        blk_first = 1'b0;
        blk_last  = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;

        test_reset_and_key();
        test_single_blocks();
        test_long_messages();
        test_back_to_back(12);
        test_key_reload();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
ghash_pkg.sv
ghash_prod_if.sv
ghash_key_sched.sv
ghash_pair_mult.sv
ghash_accum.sv
ghash_core.sv
ghash_tb.sv
